//--- common/alarm_types_pkg.sv
// Alarm record field widths, field types and the alarm class encoding
package alarm_types_pkg;

  // Field widths of one alarm record
  localparam int syn_w  = 8;
  localparam int unit_w = 4;
  localparam int aid_w  = 6;
  localparam int cls_w  = 2;

  // Whole record, packed as unit, aid, class, syndrome from high to low
  localparam int rec_w  = unit_w + aid_w + cls_w + syn_w;

  // Syndrome captured with the first strobe of an alarm
  typedef logic [syn_w-1:0]  alarm_syn_t;

  // Unit number of the node that raised the alarm
  typedef logic [unit_w-1:0] alarm_unit_t;

  // Alarm id, counted from zero inside its class
  typedef logic [aid_w-1:0]  alarm_aid_t;

  // Severity class of an alarm source, the value 3 is never produced
  typedef enum logic [cls_w-1:0] {
    class_info = 2'd0,
    class_cor  = 2'd1,
    class_unc  = 2'd2
  } alarm_class_e;

  // Flat record as held in the skid buffers
  typedef logic [rec_w-1:0] alarm_rec_t;

endpackage

//--- common/alarm_cfg_pkg.sv
// Alarm source counts per class, class base indices and derived widths
package alarm_cfg_pkg;

  // Number of local sources in each class
  localparam int num_inf = 4;
  localparam int num_cor = 4;
  localparam int num_unc = 4;

  // All local sources of one node
  localparam int num_src = num_inf + num_cor + num_unc;

  // First source index of each class above info
  localparam int cor_base = num_inf;
  localparam int unc_base = num_inf + num_cor;

  // Width of a source index within a node
  localparam int src_idx_w = $clog2(num_src);

  // One bit per local source
  typedef logic [num_src-1:0] src_vec_t;

endpackage

//--- common/alarm_stream_if.sv
// Valid/ready alarm record stream with source and sink modports
`timescale 1ns/1ps

interface alarm_stream_if;

  // Handshake, a record moves on an edge where both are high
  logic                         v;
  logic                         ready;

  // Record fields, held stable by the source while stalled
  alarm_types_pkg::alarm_unit_t  unit;
  alarm_types_pkg::alarm_aid_t   aid;
  alarm_types_pkg::alarm_class_e cls;
  alarm_types_pkg::alarm_syn_t   syn;

  // Producer side drives valid and the fields
  modport src (
    output v, unit, aid, cls, syn,
    input  ready
  );

  // Consumer side drives ready only
  modport sink (
    input  v, unit, aid, cls, syn,
    output ready
  );

endinterface

//--- verilog/alarm_skid_buffer.sv
// Two-entry double buffer for alarm records on a valid/ready stream
`timescale 1ns/1ps

module alarm_skid_buffer (
  input  logic                        hqm_inp_gated_clk,
  input  logic                        hqm_inp_gated_rst_n,
  output logic                        in_ready,
  input  logic                        in_v,
  input  alarm_types_pkg::alarm_rec_t in_data,
  input  logic                        out_ready,
  output logic                        out_v,
  output alarm_types_pkg::alarm_rec_t out_data,
  output logic                        empty
);

  alarm_types_pkg::alarm_rec_t mem_q [2];
  logic [1:0]                  cnt_q;
  logic                        wr_ptr_q;
  logic                        rd_ptr_q;
  logic                        push;
  logic                        pop;

  // Ready depends only on the fill level, there is no path from out_ready
  assign in_ready = (cnt_q != 2'd2);
  assign out_v    = (cnt_q != 2'd0);
  assign empty    = (cnt_q == 2'd0);
  assign out_data = mem_q[rd_ptr_q];

  assign push = in_v & in_ready;
  assign pop  = out_v & out_ready;

  // ----------------------------------------
  // Pointers and fill level
  always_ff @(posedge hqm_inp_gated_clk or negedge hqm_inp_gated_rst_n) begin
    if (!hqm_inp_gated_rst_n) begin
      cnt_q    <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Simultaneous push and pop leave the level unchanged
      cnt_q <= cnt_q + 2'(push) - 2'(pop);
    end
  end

  // Entry storage
  always_ff @(posedge hqm_inp_gated_clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data;
    end
  end

endmodule

//--- int_serializer/int_capture.sv
// Alarm strobe latching into a pending vector, a serialization snapshot and syndromes
`timescale 1ns/1ps

module int_capture (
  input  logic                                          hqm_inp_gated_clk,
  input  logic                                          hqm_inp_gated_rst_n,
  input  alarm_cfg_pkg::src_vec_t                       strb,
  input  alarm_types_pkg::alarm_syn_t [alarm_cfg_pkg::num_src-1:0] syn,
  input  logic                                          pop,
  input  logic [alarm_cfg_pkg::src_idx_w-1:0]           pop_idx,
  output alarm_cfg_pkg::src_vec_t                       snap,
  output alarm_types_pkg::alarm_syn_t [alarm_cfg_pkg::num_src-1:0] syn_q,
  output logic                                          busy
);

  alarm_cfg_pkg::src_vec_t pend_q;
  alarm_cfg_pkg::src_vec_t snap_q;
  alarm_cfg_pkg::src_vec_t pop_mask;
  alarm_cfg_pkg::src_vec_t pend_kept;
  alarm_cfg_pkg::src_vec_t snap_kept;
  alarm_cfg_pkg::src_vec_t pend_next;
  alarm_cfg_pkg::src_vec_t snap_next;

  // ----------------------------------------
  // Pending and snapshot update

  // One-hot mask of the entry served this cycle is zero when nothing pops
  assign pop_mask  = alarm_cfg_pkg::src_vec_t'(pop) << pop_idx;

  // Served entries leave both vectors on the popping edge
  assign pend_kept = pend_q & ~pop_mask;
  assign snap_kept = snap_q & ~pop_mask;

  // New strobes join pending and a repeat of a pending source merges into it
  assign pend_next = pend_kept | strb;

  // The snapshot only reloads once its whole burst has been served,
  // so later alarms cannot starve the ones already in it
  assign snap_next = (|snap_kept) ? snap_kept : pend_next;

  always_ff @(posedge hqm_inp_gated_clk or negedge hqm_inp_gated_rst_n) begin
    if (!hqm_inp_gated_rst_n) begin
      pend_q <= '0;
      snap_q <= '0;
    end else begin
      pend_q <= pend_next;
      snap_q <= snap_next;
    end
  end

  // ----------------------------------------
  // Syndrome storage

  // Only the first syndrome of an alarm is kept until it is served
  always_ff @(posedge hqm_inp_gated_clk) begin
    for (int i = 0; i < alarm_cfg_pkg::num_src; i++) begin
      if (strb[i] && !pend_kept[i]) begin
        syn_q[i] <= syn[i];
      end
    end
  end

  assign snap = snap_q;

  // Every snapshot entry is also pending, so pending alone shows outstanding work
  assign busy = |pend_q;

endmodule

//--- int_serializer/int_select.sv
// Lowest-index snapshot entry selection and local alarm record forming
`timescale 1ns/1ps

module int_select (
  input  alarm_cfg_pkg::src_vec_t                       snap,
  input  alarm_types_pkg::alarm_syn_t [alarm_cfg_pkg::num_src-1:0] syn_q,
  output logic                                          loc_v,
  output logic [alarm_cfg_pkg::src_idx_w-1:0]           loc_idx,
  output alarm_types_pkg::alarm_class_e                 loc_cls,
  output alarm_types_pkg::alarm_aid_t                   loc_aid,
  output alarm_types_pkg::alarm_syn_t                   loc_syn
);

  localparam logic [alarm_cfg_pkg::src_idx_w-1:0] cor_idx =
    alarm_cfg_pkg::src_idx_w'(alarm_cfg_pkg::cor_base);
  localparam logic [alarm_cfg_pkg::src_idx_w-1:0] unc_idx =
    alarm_cfg_pkg::src_idx_w'(alarm_cfg_pkg::unc_base);

  // A local record exists whenever any snapshot entry is set
  assign loc_v = |snap;

  // Priority encoder, scanning downwards so the lowest set bit wins
  always_comb begin
    loc_idx = '0;
    for (int i = alarm_cfg_pkg::num_src - 1; i >= 0; i--) begin
      if (snap[i]) begin
        loc_idx = alarm_cfg_pkg::src_idx_w'(i);
      end
    end
  end

  // Class comes from the index range, aid is the offset from the class base
  always_comb begin
    if (loc_idx >= unc_idx) begin
      loc_cls = alarm_types_pkg::class_unc;
      loc_aid = alarm_types_pkg::alarm_aid_t'(loc_idx - unc_idx);
    end else if (loc_idx >= cor_idx) begin
      loc_cls = alarm_types_pkg::class_cor;
      loc_aid = alarm_types_pkg::alarm_aid_t'(loc_idx - cor_idx);
    end else begin
      loc_cls = alarm_types_pkg::class_info;
      loc_aid = alarm_types_pkg::alarm_aid_t'(loc_idx);
    end
  end

  // Encoded index never exceeds num_src-1
  assign loc_syn = syn_q[loc_idx];

endmodule

//--- int_serializer/int_merge.sv
// Alternating arbitration between upstream and local alarm records
`timescale 1ns/1ps

module int_merge #(
  parameter alarm_types_pkg::alarm_unit_t unit = '0
) (
  input  logic                          hqm_inp_gated_clk,
  input  logic                          hqm_inp_gated_rst_n,
  alarm_stream_if.sink                  up,
  input  logic                          loc_v,
  input  alarm_types_pkg::alarm_class_e loc_cls,
  input  alarm_types_pkg::alarm_aid_t   loc_aid,
  input  alarm_types_pkg::alarm_syn_t   loc_syn,
  output logic                          loc_pop,
  alarm_stream_if.src                   down
);

  logic tog_q;
  logic up_sel;

  // ----------------------------------------
  // Record selection

  // Upstream wins when alone, or when both compete and it is its turn
  assign up_sel = up.v & ~(loc_v & ~tog_q);

  assign down.v    = up.v | loc_v;
  // Local records carry this node's unit number
  assign down.unit = up_sel ? up.unit : unit;
  assign down.aid  = up_sel ? up.aid  : loc_aid;
  assign down.cls  = up_sel ? up.cls  : loc_cls;
  assign down.syn  = up_sel ? up.syn  : loc_syn;

  // ----------------------------------------
  // Pop return

  // Exactly one side is consumed on an accepted transfer
  assign up.ready = up_sel & down.ready;
  assign loc_pop  = loc_v & ~up_sel & down.ready;

  // Turn passes to the other side after each contested transfer
  always_ff @(posedge hqm_inp_gated_clk or negedge hqm_inp_gated_rst_n) begin
    if (!hqm_inp_gated_rst_n) begin
      tog_q <= 1'b0;
    end else if (up.v && loc_v && down.ready) begin
      tog_q <= ~tog_q;
    end
  end

endmodule

//--- int_serializer/int_serializer.sv
// One alarm chain node with buffers, capture, select, merge and idle reporting
`timescale 1ns/1ps

module int_serializer #(
  parameter alarm_types_pkg::alarm_unit_t unit = '0
) (
  input  logic                                          hqm_inp_gated_clk,
  input  logic                                          hqm_inp_gated_rst_n,
  input  logic                                          rst_prep,
  input  alarm_cfg_pkg::src_vec_t                       strb,
  input  alarm_types_pkg::alarm_syn_t [alarm_cfg_pkg::num_src-1:0] syn,
  alarm_stream_if.sink                                  up,
  output logic                                          down_v,
  output alarm_types_pkg::alarm_rec_t                   down_rec,
  input  logic                                          down_ready,
  output logic                                          idle
);

  alarm_stream_if up_q ();
  alarm_stream_if down_d ();

  alarm_types_pkg::alarm_rec_t up_rec;
  logic                        up_empty;
  logic                        down_empty;
  logic                        down_out_v;
  alarm_cfg_pkg::src_vec_t     snap;
  alarm_types_pkg::alarm_syn_t [alarm_cfg_pkg::num_src-1:0] syn_q;
  logic                        busy;
  logic                        loc_v;
  logic [alarm_cfg_pkg::src_idx_w-1:0] loc_idx;
  alarm_types_pkg::alarm_class_e loc_cls;
  alarm_types_pkg::alarm_aid_t loc_aid;
  alarm_types_pkg::alarm_syn_t loc_syn;
  logic                        loc_pop;

  // ----------------------------------------
  // Upstream buffer, flattened on the way in and split on the way out
  alarm_skid_buffer up_buf_i (
    .hqm_inp_gated_clk   (hqm_inp_gated_clk),
    .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
    .in_ready            (up.ready),
    .in_v                (up.v),
    .in_data             ({up.unit, up.aid, up.cls, up.syn}),
    .out_ready           (up_q.ready),
    .out_v               (up_q.v),
    .out_data            (up_rec),
    .empty               (up_empty)
  );

  assign up_q.unit = up_rec[19:16];
  assign up_q.aid  = up_rec[15:10];
  assign up_q.cls  = alarm_types_pkg::alarm_class_e'(up_rec[9:8]);
  assign up_q.syn  = up_rec[7:0];

  // Local alarm path
  int_capture capture_i (
    .hqm_inp_gated_clk   (hqm_inp_gated_clk),
    .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
    .strb                (strb),
    .syn                 (syn),
    .pop                 (loc_pop),
    .pop_idx             (loc_idx),
    .snap                (snap),
    .syn_q               (syn_q),
    .busy                (busy)
  );

  int_select select_i (
    .snap    (snap),
    .syn_q   (syn_q),
    .loc_v   (loc_v),
    .loc_idx (loc_idx),
    .loc_cls (loc_cls),
    .loc_aid (loc_aid),
    .loc_syn (loc_syn)
  );

  int_merge #(.unit(unit)) merge_i (
    .hqm_inp_gated_clk   (hqm_inp_gated_clk),
    .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
    .up                  (up_q),
    .loc_v               (loc_v),
    .loc_cls             (loc_cls),
    .loc_aid             (loc_aid),
    .loc_syn             (loc_syn),
    .loc_pop             (loc_pop),
    .down                (down_d)
  );

  // ----------------------------------------
  // Downstream buffer, stalled while reset-prepare hides its output
  alarm_skid_buffer down_buf_i (
    .hqm_inp_gated_clk   (hqm_inp_gated_clk),
    .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
    .in_ready            (down_d.ready),
    .in_v                (down_d.v),
    .in_data             ({down_d.unit, down_d.aid, down_d.cls, down_d.syn}),
    .out_ready           (down_ready & ~rst_prep),
    .out_v               (down_out_v),
    .out_data            (down_rec),
    .empty               (down_empty)
  );

  assign down_v = down_out_v & ~rst_prep;

  // Nothing buffered and nothing waiting in capture
  assign idle = up_empty & down_empty & ~busy;

endmodule

//--- verilog/alarm_chain_top.sv
// Two chained alarm nodes with plain top-level ports
`timescale 1ns/1ps

module alarm_chain_top (
  input  logic                                          hqm_inp_gated_clk,
  input  logic                                          hqm_inp_gated_rst_n,
  input  logic                                          rst_prep,
  input  alarm_cfg_pkg::src_vec_t                       n0_strb,
  input  alarm_types_pkg::alarm_syn_t [alarm_cfg_pkg::num_src-1:0] n0_syn,
  input  alarm_cfg_pkg::src_vec_t                       n1_strb,
  input  alarm_types_pkg::alarm_syn_t [alarm_cfg_pkg::num_src-1:0] n1_syn,
  output logic                                          down_v,
  output alarm_types_pkg::alarm_unit_t                  down_unit,
  output alarm_types_pkg::alarm_aid_t                   down_aid,
  output alarm_types_pkg::alarm_class_e                 down_cls,
  output alarm_types_pkg::alarm_syn_t                   down_syn,
  input  logic                                          down_ready,
  output logic                                          idle
);

  alarm_stream_if n0_up ();
  alarm_stream_if link ();

  alarm_types_pkg::alarm_rec_t n0_rec;
  alarm_types_pkg::alarm_rec_t n1_rec;
  logic                        n0_idle;
  logic                        n1_idle;

  // Node 0 is the head of the chain and never sees upstream traffic
  assign n0_up.v    = 1'b0;
  assign n0_up.unit = '0;
  assign n0_up.aid  = '0;
  assign n0_up.cls  = alarm_types_pkg::class_info;
  assign n0_up.syn  = '0;

  int_serializer #(.unit(4'd0)) n0_i (
    .hqm_inp_gated_clk   (hqm_inp_gated_clk),
    .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
    .rst_prep            (rst_prep),
    .strb                (n0_strb),
    .syn                 (n0_syn),
    .up                  (n0_up),
    .down_v              (link.v),
    .down_rec            (n0_rec),
    .down_ready          (link.ready),
    .idle                (n0_idle)
  );

  // Node 0 records enter node 1 as its upstream stream
  assign link.unit = n0_rec[19:16];
  assign link.aid  = n0_rec[15:10];
  assign link.cls  = alarm_types_pkg::alarm_class_e'(n0_rec[9:8]);
  assign link.syn  = n0_rec[7:0];

  int_serializer #(.unit(4'd1)) n1_i (
    .hqm_inp_gated_clk   (hqm_inp_gated_clk),
    .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
    .rst_prep            (rst_prep),
    .strb                (n1_strb),
    .syn                 (n1_syn),
    .up                  (link),
    .down_v              (down_v),
    .down_rec            (n1_rec),
    .down_ready          (down_ready),
    .idle                (n1_idle)
  );

  assign down_unit = n1_rec[19:16];
  assign down_aid  = n1_rec[15:10];
  assign down_cls  = alarm_types_pkg::alarm_class_e'(n1_rec[9:8]);
  assign down_syn  = n1_rec[7:0];

  assign idle = n0_idle & n1_idle;

endmodule

//--- dv/alarm_chain_checker.sv
// Concurrent assertions on the alarm chain output stream, bound to the chain top level
`timescale 1ns/1ps

module alarm_chain_checker (
  input logic                          hqm_inp_gated_clk,
  input logic                          hqm_inp_gated_rst_n,
  input logic                          rst_prep,
  input logic                          down_v,
  input alarm_types_pkg::alarm_unit_t  down_unit,
  input alarm_types_pkg::alarm_aid_t   down_aid,
  input alarm_types_pkg::alarm_class_e down_cls,
  input alarm_types_pkg::alarm_syn_t   down_syn,
  input logic                          down_ready
);

  // One failure counter per property, summed up for the testbench
  int reset_fails = 0;
  int prep_fails  = 0;
  int hold_fails  = 0;
  int field_fails = 0;
  int cls_fails   = 0;
  int aid_fails   = 0;
  int unit_fails  = 0;
  int fail_cnt;

  assign fail_cnt = reset_fails + prep_fails + hold_fails + field_fails
                  + cls_fails + aid_fails + unit_fails;

  // ----------------------------------------
  // Output valid masking

  // Buffers are cleared by reset, so nothing may be offered
  valid_in_reset_a: assert property (
    @(posedge hqm_inp_gated_clk) !hqm_inp_gated_rst_n |-> !down_v
  ) else begin
    $error("Output valid high while reset is asserted");
    reset_fails++;
  end

  // Reset-prepare hides the output of both nodes
  valid_in_prep_a: assert property (
    @(posedge hqm_inp_gated_clk) disable iff (!hqm_inp_gated_rst_n)
    rst_prep |-> !down_v
  ) else begin
    $error("Output valid high while reset-prepare is asserted");
    prep_fails++;
  end

  // ----------------------------------------
  // Stall behavior

  // A stalled record stays offered, unless reset-prepare masks it
  stall_hold_a: assert property (
    @(posedge hqm_inp_gated_clk) disable iff (!hqm_inp_gated_rst_n)
    (down_v && !down_ready) |=> (down_v || rst_prep)
  ) else begin
    $error("Output valid dropped while the record was stalled");
    hold_fails++;
  end

  // The downstream buffer does not move while stalled
  stall_fields_a: assert property (
    @(posedge hqm_inp_gated_clk) disable iff (!hqm_inp_gated_rst_n)
    (down_v && !down_ready) |=> ($stable(down_unit) && $stable(down_aid)
                                 && $stable(down_cls) && $stable(down_syn))
  ) else begin
    $error("Record fields changed while the record was stalled");
    field_fails++;
  end

  // ----------------------------------------
  // Field ranges of an offered record
  cls_range_a: assert property (
    @(posedge hqm_inp_gated_clk) disable iff (!hqm_inp_gated_rst_n)
    down_v |-> (int'(down_cls) != 3)
  ) else begin
    $error("Record class is 3");
    cls_fails++;
  end

  // Four sources per class
  aid_range_a: assert property (
    @(posedge hqm_inp_gated_clk) disable iff (!hqm_inp_gated_rst_n)
    down_v |-> (int'(down_aid) < 4)
  ) else begin
    $error("Record aid is 4 or more");
    aid_fails++;
  end

  unit_range_a: assert property (
    @(posedge hqm_inp_gated_clk) disable iff (!hqm_inp_gated_rst_n)
    down_v |-> (int'(down_unit) <= 1)
  ) else begin
    $error("Record unit is neither 0 nor 1");
    unit_fails++;
  end

endmodule

bind alarm_chain_top alarm_chain_checker checker_i (
  .hqm_inp_gated_clk   (hqm_inp_gated_clk),
  .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
  .rst_prep            (rst_prep),
  .down_v              (down_v),
  .down_unit           (down_unit),
  .down_aid            (down_aid),
  .down_cls            (down_cls),
  .down_syn            (down_syn),
  .down_ready          (down_ready)
);

//--- dv/alarm_chain_tb.sv
// Testbench for the alarm chain with clock, reset, stimulus, scoreboard, reporting and timeout
`timescale 1ns/1ps

module alarm_chain_tb;

  localparam int n_src = alarm_cfg_pkg::num_src;
  // Every record of all tests gets 24 cycles under random stalls, with margin for fixed waits
  localparam int max_cycles = (24 + 12 + 6 * 24 + 3 + 24) * 24 + 500;

  logic                                    hqm_inp_gated_clk;
  logic                                    hqm_inp_gated_rst_n;
  logic                                    rst_prep;
  alarm_cfg_pkg::src_vec_t                 n0_strb;
  alarm_cfg_pkg::src_vec_t                 n1_strb;
  alarm_types_pkg::alarm_syn_t [n_src-1:0] n0_syn;
  alarm_types_pkg::alarm_syn_t [n_src-1:0] n1_syn;
  logic                                    down_v;
  alarm_types_pkg::alarm_unit_t            down_unit;
  alarm_types_pkg::alarm_aid_t             down_aid;
  alarm_types_pkg::alarm_class_e           down_cls;
  alarm_types_pkg::alarm_syn_t             down_syn;
  logic                                    down_ready;
  logic                                    idle;

  // Expected records come from the stimulus and arrivals from the monitor
  int exp_cnt [2][n_src];
  int got_cnt [2][n_src];
  alarm_types_pkg::alarm_syn_t exp_syn [2][n_src];
  int got_log [$];
  int exp_total;
  int got_total;
  int seq_errs;
  int mon_errs;
  int cycle_cnt;
  int tests_run;
  int tests_failed;

  alarm_chain_top dut_i (
    .hqm_inp_gated_clk   (hqm_inp_gated_clk),
    .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
    .rst_prep            (rst_prep),
    .n0_strb             (n0_strb),
    .n0_syn              (n0_syn),
    .n1_strb             (n1_strb),
    .n1_syn              (n1_syn),
    .down_v              (down_v),
    .down_unit           (down_unit),
    .down_aid            (down_aid),
    .down_cls            (down_cls),
    .down_syn            (down_syn),
    .down_ready          (down_ready),
    .idle                (idle)
  );

  initial begin
    hqm_inp_gated_clk = 1'b0;
    forever #2 hqm_inp_gated_clk = ~hqm_inp_gated_clk;
  end

  always @(posedge hqm_inp_gated_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout, the run did not finish within %0d cycles", max_cycles);
      $display("Something failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Helpers

  function automatic void report_error(input string msg);
    $display("** Error: %0t ns: %s", $time, msg);
  endfunction

  function automatic int total_errors();
    return seq_errs + mon_errs + dut_i.checker_i.fail_cnt;
  endfunction

  // First source index of each class within a node
  function automatic int class_base(input alarm_types_pkg::alarm_class_e c);
    case (c)
      alarm_types_pkg::class_cor: return alarm_cfg_pkg::cor_base;
      alarm_types_pkg::class_unc: return alarm_cfg_pkg::unc_base;
      default: return 0;
    endcase
  endfunction

  // A source with a record still outstanding merges, so its first syndrome stays
  function automatic void note_strobe(input int u, input int s,
                                      input alarm_types_pkg::alarm_syn_t syn);
    if (exp_cnt[u][s] == got_cnt[u][s]) begin
      exp_cnt[u][s]++;
      exp_syn[u][s] = syn;
      exp_total++;
    end
  endfunction

  task automatic next_cycle();
    @(posedge hqm_inp_gated_clk);
    #1;
  endtask

  // Strobes both nodes for one cycle with random syndromes unless one is given
  task automatic fire(input alarm_cfg_pkg::src_vec_t m0, input alarm_cfg_pkg::src_vec_t m1,
                      input bit use_fixed, input alarm_types_pkg::alarm_syn_t fixed_syn);
    alarm_types_pkg::alarm_syn_t s;
    for (int i = 0; i < n_src; i++) begin
      if (m0[i]) begin
        s = use_fixed ? fixed_syn : 8'($urandom);
        n0_syn[i] = s;
        note_strobe(0, i, s);
      end
      if (m1[i]) begin
        s = use_fixed ? fixed_syn : 8'($urandom);
        n1_syn[i] = s;
        note_strobe(1, i, s);
      end
    end
    n0_strb = m0;
    n1_strb = m1;
    next_cycle();
    n0_strb = '0;
    n1_strb = '0;
  endtask

  // Wait until every expected record arrived and the chain reports idle
  task automatic wait_drained(input bit rand_ready);
    do begin
      if (rand_ready) begin
        down_ready = 1'($urandom);
      end
      next_cycle();
    end while (exp_total != got_total || !idle);
    down_ready = 1'b1;
  endtask

  task automatic finish_test(input string name, input int errs_at);
    int errs;
    errs = total_errors() - errs_at;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errs);
    end
  endtask

  // ----------------------------------------
  // The monitor samples at the falling edge where the stream is stable
  always @(negedge hqm_inp_gated_clk) begin
    int u;
    int s;
    bit in_range;
    if (hqm_inp_gated_rst_n && down_v && down_ready) begin
      u = int'(down_unit);
      s = class_base(down_cls) + int'(down_aid);
      in_range = (u <= 1) && (int'(down_cls) <= 2) && (int'(down_aid) <= 3);
      assert (in_range) else begin
        report_error($sformatf("record unit %0d class %0d aid %0d out of range",
                               u, int'(down_cls), int'(down_aid)));
        mon_errs++;
      end
      if (in_range) begin
        assert (got_cnt[u][s] < exp_cnt[u][s]) else begin
          report_error($sformatf("unexpected record from unit %0d source %0d", u, s));
          mon_errs++;
        end
        assert (got_cnt[u][s] >= exp_cnt[u][s] || down_syn == exp_syn[u][s]) else begin
          report_error($sformatf("unit %0d source %0d syndrome %02h, expected %02h",
                                 u, s, down_syn, exp_syn[u][s]));
          mon_errs++;
        end
        got_cnt[u][s]++;
      end
      got_log.push_back(u * 16 + s);
      got_total++;
    end
  end

  // ----------------------------------------
  // Test sequence
  initial begin
    int base;
    int errs_at;
    alarm_cfg_pkg::src_vec_t m;
    alarm_types_pkg::alarm_syn_t first_syn;
    void'($urandom(32'ha43d_7e45));
    hqm_inp_gated_rst_n = 1'b0;
    rst_prep = 1'b0;
    n0_strb = '0;
    n1_strb = '0;
    n0_syn = '0;
    n1_syn = '0;
    down_ready = 1'b1;
    repeat (2) @(posedge hqm_inp_gated_clk);
    #1;
    hqm_inp_gated_rst_n = 1'b1;

    errs_at = total_errors();
    assert (!down_v && idle) else begin
      report_error("chain not empty and idle after reset");
      seq_errs++;
    end
    finish_test("reset state", errs_at);

    // Every source of both nodes alone
    errs_at = total_errors();
    for (int u = 0; u < 2; u++) begin
      for (int s = 0; s < n_src; s++) begin
        m = alarm_cfg_pkg::src_vec_t'(1) << s;
        fire(u == 0 ? m : '0, u == 1 ? m : '0, 1'b0, '0);
        wait_drained(1'b0);
      end
    end
    finish_test("single strobes", errs_at);

    // Same-cycle burst of node 1 leaves in ascending source order
    errs_at = total_errors();
    base = got_total;
    fire('0, '1, 1'b0, '0);
    wait_drained(1'b0);
    for (int k = 0; k < n_src; k++) begin
      assert (got_log[base + k] == 16 + k) else begin
        report_error($sformatf("burst record %0d is not unit 1 source %0d", k, k));
        seq_errs++;
      end
    end
    finish_test("ordered burst", errs_at);

    // Concurrent bursts under random back-pressure
    errs_at = total_errors();
    for (int b = 0; b < 6; b++) begin
      down_ready = 1'($urandom);
      fire(b == 0 ? '1 : 12'($urandom), b == 0 ? '1 : 12'($urandom), 1'b0, '0);
      wait_drained(1'b1);
    end
    finish_test("random stalls", errs_at);

    // Source 2 waits behind a full buffer, so its repeat strobe merges
    errs_at = total_errors();
    base = got_total;
    down_ready = 1'b0;
    fire('0, 12'b0000_0000_0011, 1'b0, '0);
    repeat (4) next_cycle();
    first_syn = 8'($urandom);
    fire('0, 12'b0000_0000_0100, 1'b1, first_syn);
    repeat (3) next_cycle();
    fire('0, 12'b0000_0000_0100, 1'b1, ~first_syn);
    down_ready = 1'b1;
    wait_drained(1'b0);
    assert (got_total - base == 3) else begin
      report_error($sformatf("%0d records after a repeated strobe, expected 3",
                             got_total - base));
      seq_errs++;
    end
    finish_test("pending merge", errs_at);

    // Reset-prepare holds everything back until it falls
    errs_at = total_errors();
    rst_prep = 1'b1;
    fire('1, '1, 1'b0, '0);
    repeat (30) begin
      next_cycle();
      assert (!down_v) else begin
        report_error("output valid high during reset-prepare");
        seq_errs++;
      end
    end
    rst_prep = 1'b0;
    // The last transfer empties the chain, so idle is due right after it
    while (exp_total != got_total) begin
      next_cycle();
    end
    assert (idle) else begin
      report_error("chain not idle after reset-prepare drain");
      seq_errs++;
    end
    finish_test("reset prepare", errs_at);

    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- compile.f
common/alarm_types_pkg.sv
common/alarm_cfg_pkg.sv
common/alarm_stream_if.sv
verilog/alarm_skid_buffer.sv
int_serializer/int_capture.sv
int_serializer/int_select.sv
int_serializer/int_merge.sv
int_serializer/int_serializer.sv
verilog/alarm_chain_top.sv
dv/alarm_chain_checker.sv
dv/alarm_chain_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the alarm chain testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module alarm_chain_tb -Mdir obj_dir -f compile.f

status=0
./obj_dir/Valarm_chain_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "^Everything OK$" sim.log; then
  exit 0
fi
exit 1
